// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f sim.f --top-module cpuTb -o cpuSim &&
./obj_dir/cpuSim | tee /dev/stderr | grep -qx "TEST PASSED" ||
{ echo "simulation did not pass"; exit 1; }

// ==== sim.f ====
source/cpuPkg.sv
source/pipeReg.sv
source/debugPort.sv
source/fetchStage.sv
source/decodeStage.sv
source/executeStage.sv
source/memoryStage.sv
source/cpuTop.sv
verification/cpuTb.sv

// ==== source/cpuPkg.sv ====
package cpuPkg;

  //////////////////////////////
  // Widths and sizes
  //////////////////////////////
  typedef logic [15:0] wordT;     // One machine word
  typedef logic [3:0]  regAddrT;  // r0..r15

  localparam int IMEM_DEPTH_DEFAULT = 64;  // Power of two, at most 256
  localparam int DMEM_DEPTH_DEFAULT = 64;

  // Opcode in bits 15:12, codes not listed act as no-ops
  typedef enum logic [3:0] {
    OP_ADD = 4'h0,
    OP_SUB = 4'h1,
    OP_AND = 4'h2,
    OP_OR  = 4'h3,
    OP_LLB = 4'h4,
    OP_LW  = 4'h8,
    OP_SW  = 4'h9,
    OP_HLT = 4'hF
  } opcodeE;

  // First four line up with opcodes 0..3
  typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_PASS} aluOpE;

  //////////////////////////////
  // Pipeline registers
  //////////////////////////////
  typedef struct packed {
    logic  regWrite;
    logic  memRead;
    logic  memWrite;
    logic  memToReg;  // Writeback from memory, not ALU
    logic  aluImm;    // B side takes the immediate
    logic  halt;
    aluOpE aluOp;
  } ctrlT;

  typedef struct packed {wordT instr; logic valid;} ifIdT;

  typedef struct packed {
    ctrlT    ctrl;
    wordT    a;       // rs value
    wordT    b;       // rt value, store data on SW
    wordT    imm;     // Sign-extended
    regAddrT rsAddr;
    regAddrT rtAddr;  // rt, or the store register on SW
    regAddrT rd;
  } idExT;

  typedef struct packed {ctrlT ctrl; wordT aluRes; wordT storeData; regAddrT rd;} exMemT;

  typedef struct packed {logic regWrite; logic halt; regAddrT rd; wordT wrData;} memWbT;

  //////////////////////////////
  // APB and debug
  //////////////////////////////
  typedef struct packed {
    logic [11:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    wordT        pwdata;
  } apbReqT;

  typedef struct packed {wordT prdata; logic pslverr;} apbRspT;

  localparam logic [11:0] CTRL_ADDR   = 12'h000;  // Bit 0 write starts a run
  localparam logic [11:0] STATUS_ADDR = 12'h004;  // Bit 0 running, bit 1 halted
  localparam logic [11:0] REG_BASE    = 12'h040;  // 16 regs, read-only
  localparam logic [11:0] IMEM_BASE   = 12'h400;  // Instruction words, write-only

  typedef struct packed {
    logic       imemWe;
    logic [7:0] imemAddr;  // Word index
    wordT       imemData;
    logic       start;     // One-cycle pulse
  } dbgCmdT;

endpackage

// ==== source/cpuTop.sv ====
`timescale 1ns/1ps

module cpuTop import cpuPkg::*; #(
  parameter int IMEM_DEPTH = IMEM_DEPTH_DEFAULT,
  parameter int DMEM_DEPTH = DMEM_DEPTH_DEFAULT
) (
  input  logic   clk,
  input  logic   rstN,
  input  apbReqT apbReq,
  output apbRspT apbRsp
);

  dbgCmdT  cmd;
  logic    running, stall, haltSeen;
  regAddrT dbgRegAddr;
  wordT    dbgRegData;
  ifIdT    ifIdD, ifIdQ;
  idExT    idExD, idExQ;
  exMemT   exMemD, exMemQ;
  memWbT   memWbD, memWbQ;

  debugPort dbg (.clk, .rstN, .apbReq, .apbRsp, .haltWb(memWbQ.halt), .running, .cmd,
                 .dbgRegAddr, .dbgRegData);

  //////////////////////////////
  // Stages and stage registers
  //////////////////////////////
  fetchStage #(.IMEM_DEPTH(IMEM_DEPTH)) fetch (.clk, .rstN, .cmd, .stall, .haltSeen,
                                               .running, .ifId(ifIdD));
  pipeReg #(.payloadT(ifIdT)) ifIdReg (.clk, .rstN, .hold(stall), .flush(cmd.start),
                                       .d(ifIdD), .q(ifIdQ));  // Held on load-use

  decodeStage decode (.clk, .rstN, .ifId(ifIdQ), .idExPrev(idExQ), .wb(memWbQ), .dbgRegAddr,
                      .dbgRegData, .stall, .haltSeen, .idEx(idExD));
  pipeReg #(.payloadT(idExT)) idExReg (.clk, .rstN, .hold(1'b0), .flush(cmd.start),
                                       .d(idExD), .q(idExQ));

  executeStage execute (.idEx(idExQ), .exMemQ, .memWbQ, .exMem(exMemD));
  pipeReg #(.payloadT(exMemT)) exMemReg (.clk, .rstN, .hold(1'b0), .flush(cmd.start),
                                         .d(exMemD), .q(exMemQ));

  memoryStage #(.DMEM_DEPTH(DMEM_DEPTH)) memory (.clk, .rstN, .exMem(exMemQ), .memWb(memWbD));
  pipeReg #(.payloadT(memWbT)) memWbReg (.clk, .rstN, .hold(1'b0), .flush(cmd.start),
                                         .d(memWbD), .q(memWbQ));  // Writeback

endmodule

// ==== source/debugPort.sv ====
`timescale 1ns/1ps

module debugPort import cpuPkg::*; (
  input  logic    clk,
  input  logic    rstN,
  input  apbReqT  apbReq,
  output apbRspT  apbRsp,
  input  logic    haltWb,      // HLT sitting in writeback
  output logic    running,
  output dbgCmdT  cmd,
  output regAddrT dbgRegAddr,
  input  wordT    dbgRegData
);

  logic halted;
  logic access;                              // Second cycle of a transfer
  logic isCtrl, isStatus, isReg, isImem;
  logic mapped, roWrite, busyWrite;

  //////////////////////////////
  // Address decode
  //////////////////////////////
  assign access   = apbReq.psel && apbReq.penable;
  assign isCtrl   = apbReq.paddr == CTRL_ADDR;
  assign isStatus = apbReq.paddr == STATUS_ADDR;
  assign isReg    = (apbReq.paddr[11:6] == REG_BASE[11:6]) && (apbReq.paddr[1:0] == 2'b00);
  assign isImem   = (apbReq.paddr[11:10] == IMEM_BASE[11:10]) && (apbReq.paddr[1:0] == 2'b00);

  assign mapped    = isCtrl || isStatus || isReg || isImem;
  assign roWrite   = apbReq.pwrite && (isStatus || isReg);
  assign busyWrite = apbReq.pwrite && isImem && running;  // No loading mid-run

  assign dbgRegAddr = apbReq.paddr[5:2];  // Word index in reg window

  // Commands to fetch, only on a clean access
  assign cmd.start    = access && apbReq.pwrite && isCtrl && apbReq.pwdata[0];
  assign cmd.imemWe   = access && apbReq.pwrite && isImem && !running;
  assign cmd.imemAddr = apbReq.paddr[9:2];
  assign cmd.imemData = apbReq.pwdata;

  // Read data and error, valid in the access cycle
  always_comb begin
    apbRsp.prdata = '0;
    if (isStatus) begin
      apbRsp.prdata = {14'b0, halted, running};
    end else if (isReg) begin
      apbRsp.prdata = dbgRegData;  // Same-cycle regfile read
    end
    apbRsp.pslverr = access && (!mapped || roWrite || busyWrite);
  end

  //////////////////////////////
  // Run status
  //////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      running <= 1'b0;
      halted  <= 1'b0;
    end else if (cmd.start) begin
      running <= 1'b1;  // Restart allowed at any time
      halted  <= 1'b0;
    end else if (haltWb) begin
      running <= 1'b0;  // HLT leaves writeback
      halted  <= 1'b1;
    end
  end

endmodule

// ==== source/decodeStage.sv ====
`timescale 1ns/1ps

module decodeStage import cpuPkg::*; (
  input  logic    clk,
  input  logic    rstN,
  input  ifIdT    ifId,
  input  idExT    idExPrev,    // Instruction now in execute
  input  memWbT   wb,          // Regfile write port
  input  regAddrT dbgRegAddr,
  output wordT    dbgRegData,
  output logic    stall,
  output logic    haltSeen,
  output idExT    idEx
);

  wordT    regFile [16];
  opcodeE  op;
  ctrlT    ctrl;
  regAddrT rsAddr, rtAddr, rdAddr;
  logic    usesRs, usesRt;
  wordT    imm;

  // r0 is zero, WB write shows through in the same cycle
  function automatic wordT readReg(regAddrT addr);
    wordT val;
    if (addr == '0) val = '0;
    else if (wb.regWrite && wb.rd == addr) val = wb.wrData;
    else val = regFile[addr];
    return val;
  endfunction

  assign op     = opcodeE'(ifId.instr[15:12]);
  assign rdAddr = ifId.instr[11:8];
  assign rsAddr = ifId.instr[7:4];                            // Also the LW/SW base
  assign rtAddr = (op == OP_SW) ? ifId.instr[11:8] : ifId.instr[3:0];

  // LLB takes 8 bits, LW/SW a 4-bit offset
  assign imm = (op == OP_LLB) ? {{8{ifId.instr[7]}}, ifId.instr[7:0]}
                              : {{12{ifId.instr[3]}}, ifId.instr[3:0]};

  //////////////////////////////
  // Control decode
  //////////////////////////////
  always_comb begin
    ctrl   = '0;
    usesRs = 1'b0;
    usesRt = 1'b0;
    if (ifId.valid) begin
      case (op)
        OP_ADD, OP_SUB, OP_AND, OP_OR: begin
          ctrl.regWrite = 1'b1;
          ctrl.aluOp    = aluOpE'({1'b0, op[1:0]});
          usesRs        = 1'b1;
          usesRt        = 1'b1;
        end
        OP_LLB: begin
          ctrl.regWrite = 1'b1;
          ctrl.aluImm   = 1'b1;
          ctrl.aluOp    = ALU_PASS;
        end
        OP_LW: begin
          ctrl = '{regWrite: 1'b1, memRead: 1'b1, memWrite: 1'b0, memToReg: 1'b1,
                   aluImm: 1'b1, halt: 1'b0, aluOp: ALU_ADD};
          usesRs = 1'b1;
        end
        OP_SW: begin
          ctrl.memWrite = 1'b1;
          ctrl.aluImm   = 1'b1;
          usesRs        = 1'b1;
          usesRt        = 1'b1;  // Store register
        end
        OP_HLT:  ctrl.halt = 1'b1;
        default: ;               // No-op
      endcase
    end
    if (rdAddr == '0) ctrl.regWrite = 1'b0;  // r0 never written, never forwarded
  end

  // Load in EX feeding a source here
  assign stall = idExPrev.ctrl.memRead && idExPrev.ctrl.regWrite &&
                 ((usesRs && rsAddr == idExPrev.rd) || (usesRt && rtAddr == idExPrev.rd));
  assign haltSeen = ctrl.halt;

  always_comb begin
    dbgRegData = readReg(dbgRegAddr);  // Third read port
    idEx       = '0;                   // Bubble while stalled
    if (!stall) begin
      idEx.ctrl   = ctrl;
      idEx.a      = readReg(rsAddr);
      idEx.b      = readReg(rtAddr);
      idEx.imm    = imm;
      idEx.rsAddr = rsAddr;
      idEx.rtAddr = rtAddr;
      idEx.rd     = rdAddr;
    end
  end

  // Register file
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < 16; i++) regFile[i] <= '0;
    end else if (wb.regWrite) begin
      regFile[wb.rd] <= wb.wrData;
    end
  end

endmodule

// ==== source/executeStage.sv ====
`timescale 1ns/1ps

module executeStage import cpuPkg::*; (
  input  idExT  idEx,
  input  exMemT exMemQ,   // One ahead
  input  memWbT memWbQ,   // Two ahead
  output exMemT exMem
);

  wordT opA, opB;
  wordT rtVal;            // Forwarded rt or store data
  wordT aluRes;

  // Youngest producer wins
  function automatic wordT fwd(regAddrT addr, wordT regVal, exMemT em, memWbT mw);
    wordT val;
    if (em.ctrl.regWrite && em.rd == addr) val = em.aluRes;
    else if (mw.regWrite && mw.rd == addr) val = mw.wrData;
    else val = regVal;
    return val;
  endfunction

  //////////////////////////////
  // Operand select and ALU
  //////////////////////////////
  always_comb begin
    opA   = fwd(idEx.rsAddr, idEx.a, exMemQ, memWbQ);
    rtVal = fwd(idEx.rtAddr, idEx.b, exMemQ, memWbQ);
    opB   = idEx.ctrl.aluImm ? idEx.imm : rtVal;

    case (idEx.ctrl.aluOp)
      ALU_ADD:  aluRes = opA + opB;   // Also LW/SW address
      ALU_SUB:  aluRes = opA - opB;
      ALU_AND:  aluRes = opA & opB;
      ALU_OR:   aluRes = opA | opB;
      ALU_PASS: aluRes = opB;         // LLB
      default:  aluRes = '0;
    endcase
  end

  always_comb begin
    exMem.ctrl      = idEx.ctrl;
    exMem.aluRes    = aluRes;
    exMem.storeData = rtVal;
    exMem.rd        = idEx.rd;
  end

endmodule

// ==== source/fetchStage.sv ====
`timescale 1ns/1ps

module fetchStage import cpuPkg::*; #(
  parameter int IMEM_DEPTH = IMEM_DEPTH_DEFAULT
) (
  input  logic   clk,
  input  logic   rstN,
  input  dbgCmdT cmd,
  input  logic   stall,     // Load-use hold from decode
  input  logic   haltSeen,  // HLT in decode this cycle
  input  logic   running,
  output ifIdT   ifId
);

  localparam int IAW = $clog2(IMEM_DEPTH);

  wordT           imem [IMEM_DEPTH];
  logic [IAW-1:0] pc;
  logic           stopped;  // HLT already went past decode
  logic           issue;

  // Word behind a HLT is dropped as well
  assign issue = running && !stopped && !haltSeen;

  // Instruction memory, loaded over APB
  always_ff @(posedge clk) begin
    if (cmd.imemWe) begin
      imem[cmd.imemAddr[IAW-1:0]] <= cmd.imemData;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pc      <= '0;
      stopped <= 1'b0;
    end else if (cmd.start) begin
      pc      <= '0;  // New run from address zero
      stopped <= 1'b0;
    end else begin
      if (haltSeen) stopped <= 1'b1;
      if (issue && !stall) pc <= pc + 1'b1;
    end
  end

  assign ifId.instr = imem[pc];
  assign ifId.valid = issue;  // Bubble when idle or stopped

endmodule

// ==== source/memoryStage.sv ====
`timescale 1ns/1ps

module memoryStage import cpuPkg::*; #(
  parameter int DMEM_DEPTH = DMEM_DEPTH_DEFAULT
) (
  input  logic  clk,
  input  logic  rstN,
  input  exMemT exMem,
  output memWbT memWb
);

  localparam int DAW = $clog2(DMEM_DEPTH);

  wordT           dmem [DMEM_DEPTH];
  logic [DAW-1:0] addr;   // Word address, upper bits ignored
  wordT           rdData;

  assign addr   = exMem.aluRes[DAW-1:0];
  assign rdData = dmem[addr];  // Combinational read

  // Cleared on reset, kept across runs
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < DMEM_DEPTH; i++) dmem[i] <= '0;
    end else if (exMem.ctrl.memWrite) begin
      dmem[addr] <= exMem.storeData;
    end
  end

  always_comb begin
    memWb.regWrite = exMem.ctrl.regWrite;
    memWb.halt     = exMem.ctrl.halt;
    memWb.rd       = exMem.rd;
    memWb.wrData   = exMem.ctrl.memToReg ? rdData : exMem.aluRes;
  end

endmodule

// ==== source/pipeReg.sv ====
`timescale 1ns/1ps

// Stage register shared by all four pipeline boundaries
module pipeReg #(
  parameter type payloadT = logic [0:0]
) (
  input  logic    clk,
  input  logic    rstN,
  input  logic    hold,   // Keep current contents
  input  logic    flush,  // Load a bubble
  input  payloadT d,
  output payloadT q
);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      q <= '0;
    end else if (flush) begin
      q <= '0;  // All zeros is a bubble for every payload
    end else if (!hold) begin
      q <= d;
    end
  end

endmodule

// ==== verification/cpuTb.sv ====
`timescale 1ns/1ps

module cpuTb import cpuPkg::*; ();

  localparam int CLK_PERIOD = 40;
  localparam int PROG_LEN   = 30;                  // Closing HLT included
  localparam int POOL       = 5;                   // r0..r4, dense dependencies
  localparam int DMEM_WORDS = DMEM_DEPTH_DEFAULT;
  localparam int NUM_RUNS   = 6;                   // Programs over all tests
  // Load, run, readback and slack per program
  localparam int RUN_CYCLES = PROG_LEN * 3 + PROG_LEN * 4 + 16 * 3 + 100;
  localparam int WATCHDOG_CYCLES = NUM_RUNS * RUN_CYCLES + 50;

  logic        clk;
  logic        rstN;
  apbReqT      apbReq;
  apbRspT      apbRsp;
  logic [31:0] rngState;
  wordT        prog [PROG_LEN];
  wordT        modelReg [16];                      // Reference ISA state
  wordT        modelMem [DMEM_WORDS];
  int          errCount;
  int          testCount;
  int          testFails;
  int          testStartErr;

  cpuTop #(.IMEM_DEPTH(IMEM_DEPTH_DEFAULT), .DMEM_DEPTH(DMEM_DEPTH_DEFAULT)) DUT (
    .clk, .rstN, .apbReq, .apbRsp);

  always #(CLK_PERIOD / 2) clk = ~clk;

  //////////////////////////////
  // Checks and random numbers
  //////////////////////////////
  task automatic checkEq(input string name, input wordT expected, input wordT actual);
    if (expected !== actual) begin
      $display("ERROR %s: expected %h, actual %h", name, expected, actual);
      errCount++;
    end
  endtask

  function automatic logic [31:0] xorshift();
    logic [31:0] x;
    x = rngState;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rngState = x;
    return x;
  endfunction

  function automatic int pick(input int n);
    logic [31:0] r;
    r = xorshift();
    return int'(r % n);  // 0..n-1
  endfunction

  //////////////////////////////
  // APB transfers
  //////////////////////////////
  // Entered and left 2 ns after a rising edge
  task automatic transfer(input logic wr, input logic [11:0] addr, input wordT wdata,
                          output wordT rdata, output logic err);
    apbReq.paddr   = addr;           // Setup cycle
    apbReq.pwrite  = wr;
    apbReq.pwdata  = wdata;
    apbReq.psel    = 1'b1;
    apbReq.penable = 1'b0;
    @(posedge clk);
    #2;
    apbReq.penable = 1'b1;           // Access cycle
    #10;
    rdata = apbRsp.prdata;           // Settled mid-cycle
    err   = apbRsp.pslverr;
    @(posedge clk);
    #2;
    apbReq.psel    = 1'b0;
    apbReq.penable = 1'b0;
  endtask

  task automatic busWrite(input logic [11:0] addr, input wordT data, input logic expErr,
                          input string name);
    wordT rdata;
    logic err;
    transfer(1'b1, addr, data, rdata, err);
    checkEq($sformatf("%s write %h pslverr", name, addr), 16'(expErr), 16'(err));
  endtask

  task automatic busRead(input logic [11:0] addr, input logic expErr, input string name,
                         output wordT data);
    logic err;
    transfer(1'b0, addr, 16'h0000, data, err);
    checkEq($sformatf("%s read %h pslverr", name, addr), 16'(expErr), 16'(err));
  endtask

  task automatic compareRegs(input string name);
    wordT val;
    for (int i = 0; i < 16; i++) begin
      busRead(REG_BASE + 12'(4 * i), 1'b0, name, val);
      checkEq($sformatf("%s r%0d", name, i), modelReg[i], val);
    end
  endtask

  //////////////////////////////
  // Programs and ISA model
  //////////////////////////////
  // Mode 0 ALU and LLB, mode 1 adds LW and SW
  task automatic genProgram(input int mode);
    int         kind;
    logic [3:0] rd, rs, rt;
    logic [3:0] prevRd;
    logic       prevLoad;
    prevLoad = 1'b0;
    prevRd   = 4'd0;
    for (int i = 0; i < PROG_LEN - 1; i++) begin
      rd   = 4'(pick(POOL));
      rs   = 4'(pick(POOL));
      rt   = 4'(pick(POOL));
      kind = (mode == 0) ? pick(3) : pick(8);
      if (prevLoad) begin
        kind = 1;                    // Use right behind the load
        rs   = prevRd;
      end
      case (kind)
        0:       prog[i] = {OP_LLB, rd, 8'(pick(256))};
        1, 2, 3: prog[i] = {4'(pick(4)), rd, rs, rt};  // ADD SUB AND OR
        4, 5:    prog[i] = {OP_LW, rd, rs, 4'(pick(16))};
        default: prog[i] = {OP_SW, rd, rs, 4'(pick(16))};
      endcase
      prevLoad = (kind == 4) || (kind == 5);
      prevRd   = rd;
    end
    prog[PROG_LEN-1] = {OP_HLT, 12'h000};
  endtask

  // Sequential execution, one instruction at a time
  function automatic void modelRun();
    wordT       ins, res, ea;
    logic       wr;
    logic [3:0] rd, rs, rt;
    int         addr;
    for (int i = 0; i < PROG_LEN; i++) begin
      ins  = prog[i];
      rd   = ins[11:8];
      rs   = ins[7:4];
      rt   = ins[3:0];
      wr   = 1'b1;
      res  = 16'h0000;
      ea   = modelReg[rs] + {{12{ins[3]}}, ins[3:0]};
      addr = int'(ea) % DMEM_WORDS;  // Memory wraps at its depth
      case (ins[15:12])
        OP_ADD: res = modelReg[rs] + modelReg[rt];
        OP_SUB: res = modelReg[rs] - modelReg[rt];
        OP_AND: res = modelReg[rs] & modelReg[rt];
        OP_OR:  res = modelReg[rs] | modelReg[rt];
        OP_LLB: res = {{8{ins[7]}}, ins[7:0]};
        OP_LW:  res = modelMem[addr];
        OP_SW: begin
          modelMem[addr] = modelReg[rd];
          wr = 1'b0;
        end
        default: wr = 1'b0;          // HLT
      endcase
      if (wr && rd != 4'd0) modelReg[rd] = res;  // r0 stays zero
    end
  endfunction

  // Load, start, poll STATUS to halt, then step the model
  task automatic runProgram(input string name, input logic probeErrors);
    wordT status;
    int   polls;
    for (int i = 0; i < PROG_LEN; i++) begin
      busWrite(IMEM_BASE + 12'(4 * i), prog[i], 1'b0, name);
    end
    busWrite(CTRL_ADDR, 16'h0001, 1'b0, name);
    busRead(STATUS_ADDR, 1'b0, name, status);
    checkEq({name, " status after start"}, 16'h0001, status);
    if (probeErrors) begin
      // Target r15 lies outside the register pool
      busWrite(IMEM_BASE + 12'(4 * (PROG_LEN - 2)), {OP_LLB, 4'd15, 8'h5A}, 1'b1, name);
      busWrite(STATUS_ADDR, 16'h0003, 1'b1, name);  // Read-only
      busRead(12'h100, 1'b1, name, status);         // Unmapped hole
    end
    polls = 0;
    status = 16'h0000;
    while (!status[1] && polls < PROG_LEN * 4) begin
      busRead(STATUS_ADDR, 1'b0, name, status);
      polls++;
    end
    if (!status[1]) begin
      $display("%s: core never reported halted after %0d status polls", name, polls);
      errCount++;
    end
    checkEq({name, " status at end"}, 16'h0002, status);
    modelRun();
  endtask

  task automatic endTest(input string name);
    testCount++;
    if (errCount == testStartErr) begin
      $display("%s: pass", name);
    end else begin
      $display("%s: fail with %0d errors", name, errCount - testStartErr);
      testFails++;
    end
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////
  initial begin
    wordT status;
    clk       = 1'b0;
    rstN      = 1'b0;
    apbReq    = '0;
    rngState  = 32'd53028;
    errCount  = 0;
    testCount = 0;
    testFails = 0;
    for (int i = 0; i < 16; i++) modelReg[i] = 16'h0000;
    for (int i = 0; i < DMEM_WORDS; i++) modelMem[i] = 16'h0000;
    repeat (10) @(posedge clk);
    #2;
    rstN = 1'b1;
    @(posedge clk);
    #2;

    testStartErr = errCount;         // Idle after reset
    busRead(STATUS_ADDR, 1'b0, "reset", status);
    checkEq("reset status", 16'h0000, status);
    compareRegs("reset");
    endTest("reset");

    testStartErr = errCount;         // Forwarding and write-through
    genProgram(0);
    runProgram("alu", 1'b0);
    compareRegs("alu");
    endTest("alu");

    testStartErr = errCount;         // Load-use stalls
    genProgram(1);
    runProgram("loadStore", 1'b0);
    compareRegs("loadStore");
    endTest("loadStore");

    testStartErr = errCount;
    genProgram(1);
    runProgram("apbErrors", 1'b1);
    compareRegs("apbErrors");
    endTest("apbErrors");

    testStartErr = errCount;         // State carried across runs
    for (int r = 0; r < 3; r++) begin
      genProgram(1);
      runProgram($sformatf("backToBack%0d", r), 1'b0);
      compareRegs($sformatf("backToBack%0d", r));
    end
    endTest("backToBack");

    $display("%0d tests, %0d passed, %0d failed, %0d errors", testCount,
             testCount - testFails, testFails, errCount);
    if (errCount == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Simulation stopped by the watchdog after %0d cycles", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

endmodule
